// File: tb.f
hdl/frame_pkg.sv
hdl/mem_pkg.sv
hdl/frame_if.sv
hdl/frame_ctrl.sv
hdl/osd_regs.sv
hdl/rom_loader.sv
hdl/rom_port.sv
hdl/emu_top.sv
+incdir+verif
verif/tb_emu.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_emu -f tb.f -o tb_emu_sim

# The simulator exits non-zero on a failure; the log decides
./obj_dir/tb_emu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log

// File: verif/tb_axi_tasks.svh
//////////////////////////////////////////////////
// AXI4-Lite access, game read and compare tasks
//////////////////////////////////////////////////

`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

localparam int WAIT_LIMIT = 64;

task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("** Error at %0t ns: %s got %h, expected %h", $time, what, got, exp);
        $display("STATUS: FAIL");
        $fatal(1, "value mismatch");
    end
endtask

task automatic report_timeout(input string what);
    $display("Timeout: %s did not finish within the allowed cycles", what);
    $display("STATUS: FAIL");
    $fatal(1, "handshake timeout");
endtask

// One write, address and data presented together
task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                         input logic [3:0] strb, output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b1;
    n = 0;
    // Ready sampled mid-cycle, accept at the next edge
    do begin
        @(negedge clk_sys);
        n++;
        if (n > WAIT_LIMIT)
            report_timeout("AXI write address and data accept");
        check_val("wready with awready", 32'(wready), 32'(awready));
    end while (!awready);
    @(posedge clk_sys);
    #1;
    check_val("awready after accept", 32'(awready), 0);
    check_val("bvalid one cycle after accept", 32'(bvalid), 1);
    resp    = bresp;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(posedge clk_sys);
    #1;
    bready = 1'b0;
endtask

task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b1;
    n = 0;
    do begin
        @(negedge clk_sys);
        n++;
        if (n > WAIT_LIMIT)
            report_timeout("AXI read address accept");
    end while (!arready);
    @(posedge clk_sys);
    #1;
    check_val("arready after accept", 32'(arready), 0);
    check_val("rvalid one cycle after accept", 32'(rvalid), 1);
    data    = rdata;
    resp    = rresp;
    arvalid = 1'b0;
    @(posedge clk_sys);
    #1;
    rready = 1'b0;
endtask

// Game side ROM read, latencies counted from the request
task automatic game_read(input logic [9:0] addr, output logic [15:0] data,
                         output int ack_lat, output int rdy_lat);
    int n;
    sdram_addr = addr;
    sdram_req  = 1'b1;
    n = 0;
    do begin
        @(posedge clk_sys);
        #1;
        n++;
        if (n > WAIT_LIMIT)
            report_timeout("ROM read acknowledge");
    end while (!sdram_ack);
    ack_lat   = n;
    sdram_req = 1'b0;
    n = 0;
    do begin
        @(posedge clk_sys);
        #1;
        n++;
        if (n > WAIT_LIMIT)
            report_timeout("ROM read data ready");
    end while (!data_rdy);
    rdy_lat = ack_lat + n;
    data    = data_read;
    // Let the read FSM return to idle
    @(posedge clk_sys);
    #1;
endtask

`endif

// File: verif/tb_emu.sv
//////////////////////////////////////////////////
// Testbench for the platform frame top
//////////////////////////////////////////////////

module tb_emu;
    timeunit 1ns;
    timeprecision 1ps;
    import frame_pkg::*;
    import mem_pkg::*;

    typedef enum logic [3:0] {
        OP_AXI_WR, OP_AXI_RD, OP_LOAD, OP_GAME_RD, OP_DROP_LOCK,
        OP_DL, OP_NO_ACK, OP_HOLD, OP_RELEASE, OP_DIP
    } op_t;

    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] exp;
        logic [1:0]  resp;
    } step_t;

    logic clk_sys = 1'b0;
    logic RESET;
    logic pll_locked, downloading;
    logic [24:0] ioctl_addr;
    logic [7:0] ioctl_data;
    logic ioctl_wr;
    logic [3:0] awaddr, araddr, wstrb;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [31:0] wdata, rdata, dipsw;
    logic [1:0] bresp, rresp;
    logic sdram_req, sdram_ack, data_rdy;
    logic [ROM_AW-1:0] sdram_addr;
    logic [ROM_DW-1:0] data_read;
    logic pll_rst, game_rst, dip_pause, dip_flip, dip_test;

    step_t      steps[$];
    logic [7:0] rom_bytes [ROM_BYTES];

    emu_top u_dut (.*);

    always #2 clk_sys = ~clk_sys;

    `include "tb_axi_tasks.svh"

    function automatic void add(op_t op, logic [31:0] addr, logic [31:0] data,
                                logic [3:0] strb, logic [31:0] exp, logic [1:0] resp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.strb = strb;
        s.exp  = exp;
        s.resp = resp;
        steps.push_back(s);
    endfunction

    task automatic apply_step(input step_t s);
        logic [31:0] d;
        logic [15:0] w;
        logic [1:0]  r;
        int          n;
        int          lat_a;
        int          lat_r;
        case (s.op)
            OP_AXI_WR: begin
                axi_write(s.addr[3:0], s.data, s.strb, r);
                check_val("write response", 32'(r), 32'(s.resp));
            end
            OP_AXI_RD: begin
                axi_read(s.addr[3:0], d, r);
                check_val("read data", d, s.exp);
                check_val("read response", 32'(r), 32'(s.resp));
                if (s.addr[3:0] == REG_DIPSW)
                    check_val("dipsw port", dipsw, s.exp);
            end
            OP_LOAD: begin
                ioctl_addr = s.addr[24:0];
                ioctl_data = s.data[7:0];
                ioctl_wr   = 1'b1;
                @(posedge clk_sys);
                #1;
                ioctl_wr = 1'b0;
            end
            OP_GAME_RD: begin
                game_read(s.addr[9:0], w, lat_a, lat_r);
                check_val("ROM word", 32'(w), s.exp);
                check_val("ack latency", lat_a, 1);
                check_val("rdy latency", lat_r, 2);
            end
            OP_DL: begin
                downloading = s.data[0];
                @(posedge clk_sys);
                #1;
            end
            OP_NO_ACK: begin
                sdram_addr = s.addr[9:0];
                sdram_req  = 1'b1;
                repeat (8) begin
                    @(posedge clk_sys);
                    #1;
                    check_val("ack during download", 32'(sdram_ack), 0);
                end
                sdram_req = 1'b0;
                @(posedge clk_sys);
                #1;
            end
            OP_HOLD: begin
                repeat (2) begin
                    @(posedge clk_sys);
                    #1;
                end
                check_val("game_rst level", 32'(game_rst), s.exp);
            end
            OP_RELEASE: begin
                n = 0;
                while (game_rst) begin
                    @(posedge clk_sys);
                    #1;
                    n++;
                    if (n > WAIT_LIMIT)
                        report_timeout("game reset release");
                end
                // Cycles from the step start until game_rst falls
                check_val("game_rst hold length", n, s.exp);
            end
            OP_DIP: begin
                check_val("dip outputs", {29'd0, dip_test, dip_flip, dip_pause}, s.exp);
            end
            OP_DROP_LOCK: begin
                pll_locked = 1'b0;
                n = 0;
                while (!pll_rst) begin
                    @(posedge clk_sys);
                    #1;
                    n++;
                    if (n > WAIT_LIMIT)
                        report_timeout("PLL reset rise");
                end
                check_val("pll_rst rise latency", n, 1);
                n = 0;
                while (pll_rst) begin
                    check_val("game_rst during PLL reset", 32'(game_rst), 1);
                    if (n == 10)
                        pll_locked = 1'b1;
                    @(posedge clk_sys);
                    #1;
                    n++;
                    if (n > PLL_RST_CYCLES + WAIT_LIMIT)
                        report_timeout("PLL reset fall");
                end
                check_val("pll_rst length", n, s.exp);
            end
            default: check_val("known opcode", 0, 1);
        endcase
    endtask

    initial begin
        int unsigned b;
        int          in_cnt;
        int          order [64];
        int          j;
        int          t;

        RESET = 1'b1;
        pll_locked = 1'b1;
        downloading = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        ioctl_wr = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        sdram_req = 1'b0;
        sdram_addr = '0;
        void'($urandom(91));

        // Reset release, register map, status reset bit
        add(OP_RELEASE, 0, 0, 0, RST_HOLD_CYCLES, AXI_OKAY);
        add(OP_AXI_WR, REG_STATUS, 32'hA5A5_000E, 4'b0011, 0, AXI_OKAY);
        add(OP_AXI_WR, REG_STATUS, 32'h1234_5600, 4'b1100, 0, AXI_OKAY);
        add(OP_AXI_RD, REG_STATUS, 0, 0, 32'h1234_000E, AXI_OKAY);
        add(OP_DIP, 0, 0, 0, 32'h7, AXI_OKAY);
        // One status bit at a time so a swapped DIP output shows
        add(OP_AXI_WR, REG_STATUS, 32'h0000_0002, 4'b0001, 0, AXI_OKAY);
        add(OP_DIP, 0, 0, 0, 32'h1, AXI_OKAY);
        add(OP_AXI_WR, REG_STATUS, 32'h0000_0004, 4'b0001, 0, AXI_OKAY);
        add(OP_DIP, 0, 0, 0, 32'h2, AXI_OKAY);
        add(OP_AXI_WR, REG_DIPSW, 32'hDEAD_BEEF, 4'b1111, 0, AXI_OKAY);
        add(OP_AXI_WR, REG_DIPSW, 32'h00FF_0000, 4'b0100, 0, AXI_OKAY);
        add(OP_AXI_RD, REG_DIPSW, 0, 0, 32'hDEFF_BEEF, AXI_OKAY);
        add(OP_AXI_RD, REG_CORE_ID, 0, 0, CORE_ID, AXI_OKAY);
        add(OP_AXI_WR, REG_CORE_ID, 32'hFFFF_FFFF, 4'b1111, 0, AXI_SLVERR);
        add(OP_AXI_RD, 4'h2, 0, 0, 0, AXI_SLVERR);
        // Unmapped write leaves the DIP word alone
        add(OP_AXI_WR, 4'h6, 32'h1111_1111, 4'b1111, 0, AXI_SLVERR);
        add(OP_AXI_RD, REG_DIPSW, 0, 0, 32'hDEFF_BEEF, AXI_OKAY);
        add(OP_AXI_WR, REG_STATUS, 32'h0000_0001, 4'b0001, 0, AXI_OKAY);
        add(OP_HOLD, 0, 0, 0, 1, AXI_OKAY);
        add(OP_AXI_WR, REG_STATUS, 32'h0000_000E, 4'b0001, 0, AXI_OKAY);
        // Write task already spent one cycle on the B handshake
        add(OP_RELEASE, 0, 0, 0, RST_HOLD_CYCLES - 1, AXI_OKAY);

        ////////////////////////////////////////////////
        // ROM download with a few dropped bytes
        ////////////////////////////////////////////////
        in_cnt = 0;
        add(OP_DL, 0, 1, 0, 0, AXI_OKAY);
        add(OP_HOLD, 0, 0, 0, 1, AXI_OKAY);
        for (int a = 0; a < 128; a++) begin
            b = $urandom % 256;
            rom_bytes[a] = b[7:0];
            in_cnt++;
            add(OP_LOAD, a, b, 0, 0, AXI_OKAY);
        end
        add(OP_LOAD, ROM_BYTES, $urandom % 256, 0, 0, AXI_OKAY);
        add(OP_LOAD, ROM_BYTES + 1, $urandom % 256, 0, 0, AXI_OKAY);
        add(OP_LOAD, ROM_BYTES + 452, $urandom % 256, 0, 0, AXI_OKAY);
        add(OP_NO_ACK, 5, 0, 0, 0, AXI_OKAY);
        add(OP_AXI_RD, REG_LOAD_CNT, 0, 0, in_cnt, AXI_OKAY);
        add(OP_DL, 0, 0, 0, 0, AXI_OKAY);
        // Download step already spent one cycle after the fall
        add(OP_RELEASE, 0, 0, 0, RST_HOLD_CYCLES - 1, AXI_OKAY);

        // Readback in shuffled order
        for (int i = 0; i < 64; i++)
            order[i] = i;
        for (int i = 63; i > 0; i--) begin
            j = $urandom % (i + 1);
            t = order[i];
            order[i] = order[j];
            order[j] = t;
        end
        for (int i = 0; i < 64; i++)
            add(OP_GAME_RD, order[i], 0, 0,
                {16'd0, rom_bytes[2*order[i]+1], rom_bytes[2*order[i]]}, AXI_OKAY);

        // PLL supervision
        add(OP_DROP_LOCK, 0, 0, 0, PLL_RST_CYCLES, AXI_OKAY);
        add(OP_RELEASE, 0, 0, 0, RST_HOLD_CYCLES, AXI_OKAY);

        repeat (4) @(posedge clk_sys);
        #1;
        RESET = 1'b0;

        foreach (steps[i])
            apply_step(steps[i]);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: hdl/emu_top.sv
//////////////////////////////////////////////////
// Platform frame top with plain ports
//////////////////////////////////////////////////

module emu_top (
    input  logic                        clk_sys,
    input  logic                        RESET,
    input  logic                        pll_locked,
    input  logic                        downloading,
    // ROM download
    input  logic [24:0]                 ioctl_addr,
    input  logic [7:0]                  ioctl_data,
    input  logic                        ioctl_wr,
    // Host registers
    input  logic [3:0]                  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic [3:0]                  wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [3:0]                  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // Game ROM access
    input  logic                        sdram_req,
    input  logic [mem_pkg::ROM_AW-1:0]  sdram_addr,
    output logic                        sdram_ack,
    output logic                        data_rdy,
    output logic [mem_pkg::ROM_DW-1:0]  data_read,
    // Board
    output logic                        pll_rst,
    output logic                        game_rst,
    output logic [31:0]                 dipsw,
    output logic                        dip_pause,
    output logic                        dip_flip,
    output logic                        dip_test
);
    import frame_pkg::*;
    import mem_pkg::*;

    logic [31:0] status;
    logic [11:0] load_count;
    mem_sel_t    mem_sel;

    rom_wr_if wr_bus ();
    rom_rd_if rd_bus ();

    // Game side of the read bus
    assign rd_bus.req  = sdram_req;
    assign rd_bus.addr = sdram_addr;
    assign sdram_ack   = rd_bus.ack;
    assign data_rdy    = rd_bus.rdy;
    assign data_read   = rd_bus.data;

    assign dip_pause = status[STATUS_PAUSE_BIT];
    assign dip_flip  = status[STATUS_FLIP_BIT];
    assign dip_test  = status[STATUS_TEST_BIT];

    frame_ctrl u_ctrl (
        .clk_sys     ( clk_sys     ),
        .RESET       ( RESET       ),
        .pll_locked  ( pll_locked  ),
        .downloading ( downloading ),
        .status      ( status      ),
        .pll_rst     ( pll_rst     ),
        .game_rst    ( game_rst    ),
        .mem_sel     ( mem_sel     )
    );

    osd_regs u_regs (
        .clk_sys     ( clk_sys     ),
        .RESET       ( RESET       ),
        .awaddr      ( awaddr      ),
        .awvalid     ( awvalid     ),
        .awready     ( awready     ),
        .wdata       ( wdata       ),
        .wstrb       ( wstrb       ),
        .wvalid      ( wvalid      ),
        .wready      ( wready      ),
        .bresp       ( bresp       ),
        .bvalid      ( bvalid      ),
        .bready      ( bready      ),
        .araddr      ( araddr      ),
        .arvalid     ( arvalid     ),
        .arready     ( arready     ),
        .rdata       ( rdata       ),
        .rresp       ( rresp       ),
        .rvalid      ( rvalid      ),
        .rready      ( rready      ),
        .load_count  ( load_count  ),
        .status      ( status      ),
        .dipsw       ( dipsw       )
    );

    rom_loader u_loader (
        .clk_sys     ( clk_sys     ),
        .RESET       ( RESET       ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .wr          ( wr_bus      ),
        .load_count  ( load_count  )
    );

    rom_port u_rom (
        .clk_sys     ( clk_sys     ),
        .RESET       ( RESET       ),
        .mem_sel     ( mem_sel     ),
        .wr          ( wr_bus      ),
        .rd          ( rd_bus      )
    );

endmodule

// File: hdl/rom_port.sv
//////////////////////////////////////////////////
// ROM buffer with prog writes and game read
// handshake
//////////////////////////////////////////////////

module rom_port (
    input  logic              clk_sys,
    input  logic              RESET,
    input  mem_pkg::mem_sel_t mem_sel,
    rom_wr_if.mem             wr,
    rom_rd_if.mem             rd
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ACK,
        RD_RDY
    } rd_state_t;

    logic [ROM_DW-1:0] rom_buf [ROM_WORDS];
    rd_state_t         rd_state;

    // Byte-masked writes from the loader
    always_ff @(posedge clk_sys) begin
        if (wr.prog_we) begin
            if (wr.prog_mask[0])
                rom_buf[wr.prog_addr][7:0] <= wr.prog_data[7:0];
            if (wr.prog_mask[1])
                rom_buf[wr.prog_addr][15:8] <= wr.prog_data[15:8];
        end
    end

    //////////////////////////////////////////////////
    // Read handshake
    //////////////////////////////////////////////////

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            rd_state <= RD_IDLE;
            rd.ack   <= 1'b0;
            rd.rdy   <= 1'b0;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    // Requests wait while the loader owns the buffer
                    if (rd.req && mem_sel == MEM_READ) begin
                        rd.ack   <= 1'b1;
                        rd_state <= RD_ACK;
                    end
                end
                RD_ACK: begin
                    rd.ack   <= 1'b0;
                    rd.rdy   <= 1'b1;
                    rd_state <= RD_RDY;
                end
                default: begin
                    rd.rdy   <= 1'b0;
                    rd_state <= RD_IDLE;
                end
            endcase
        end
    end

    // Address still held by the game during ack
    always_ff @(posedge clk_sys) begin
        if (rd_state == RD_ACK)
            rd.data <= rom_buf[rd.addr];
    end

    a_no_ack_prog: assert property (@(posedge clk_sys) disable iff (RESET)
        rd.ack |-> mem_sel == MEM_READ);

    a_rdy_after_ack: assert property (@(posedge clk_sys) disable iff (RESET)
        rd.ack |=> rd.rdy && !rd.ack);

    a_rdy_from_ack: assert property (@(posedge clk_sys) disable iff (RESET)
        rd.rdy |-> $past(rd.ack));

endmodule

// File: hdl/rom_loader.sv
//////////////////////////////////////////////////
// Host byte stream to byte-lane ROM writes
//////////////////////////////////////////////////

module rom_loader (
    input  logic        clk_sys,
    input  logic        RESET,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    rom_wr_if.loader    wr,
    output logic [11:0] load_count
);
    import mem_pkg::*;

    logic byte_ok;
    logic take;

    // Anything past the buffer is dropped
    assign byte_ok = ioctl_addr < 25'(ROM_BYTES);
    assign take    = ioctl_wr & byte_ok;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            wr.prog_we <= 1'b0;
            load_count <= '0;
        end else begin
            wr.prog_we <= take;
            // Count saturates at all ones
            if (take && load_count != '1)
                load_count <= load_count + 12'd1;
        end
    end

    // Same byte on both lanes, mask picks the half
    always_ff @(posedge clk_sys) begin
        if (take) begin
            wr.prog_addr <= ioctl_addr[ROM_AW:1];
            wr.prog_data <= {2{ioctl_data}};
            wr.prog_mask <= ioctl_addr[0] ? 2'b10 : 2'b01;
        end
    end

endmodule

// File: hdl/osd_regs.sv
//////////////////////////////////////////////////
// AXI4-Lite register block with status, DIP,
// core ID and load count
//////////////////////////////////////////////////

module osd_regs (
    input  logic        clk_sys,
    input  logic        RESET,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic [11:0] load_count,
    output logic [31:0] status,
    output logic [31:0] dipsw
);
    import frame_pkg::*;

    logic wr_take;

    // Byte strobe merge
    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b])
                res[b*8 +: 8] = new_val[b*8 +: 8];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Write channel
    //////////////////////////////////////////////////

    // Address and data accepted together, stalled by a pending B
    assign wr_take = awvalid & wvalid & ~bvalid;
    assign awready = wr_take;
    assign wready  = wr_take;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            status <= '0;
            dipsw  <= '0;
            bvalid <= 1'b0;
            bresp  <= AXI_OKAY;
        end else if (wr_take) begin
            bvalid <= 1'b1;
            case (awaddr)
                REG_STATUS: begin
                    status <= merge_bytes(status, wdata, wstrb);
                    bresp  <= AXI_OKAY;
                end
                REG_DIPSW: begin
                    dipsw <= merge_bytes(dipsw, wdata, wstrb);
                    bresp <= AXI_OKAY;
                end
                default: bresp <= AXI_SLVERR;
            endcase
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Read channel
    //////////////////////////////////////////////////

    assign arready = arvalid & ~rvalid;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= AXI_OKAY;
        end else if (arready) begin
            rvalid <= 1'b1;
            rresp  <= AXI_OKAY;
            case (araddr)
                REG_STATUS:   rdata <= status;
                REG_DIPSW:    rdata <= dipsw;
                REG_CORE_ID:  rdata <= CORE_ID;
                REG_LOAD_CNT: rdata <= {20'd0, load_count};
                default: begin
                    rdata <= '0;
                    rresp <= AXI_SLVERR;
                end
            endcase
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // A pending response stays put until the host takes it
    a_b_held: assert property (@(posedge clk_sys) disable iff (RESET)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)));

endmodule

// File: hdl/frame_ctrl.sv
//////////////////////////////////////////////////
// Control FSM with PLL supervisor, game reset hold
// and memory path select
//////////////////////////////////////////////////

module frame_ctrl (
    input  logic              clk_sys,
    input  logic              RESET,
    input  logic              pll_locked,
    input  logic              downloading,
    input  logic [31:0]       status,
    output logic              pll_rst,
    output logic              game_rst,
    output mem_pkg::mem_sel_t mem_sel
);
    import frame_pkg::*;
    import mem_pkg::*;

    frame_state_t          state;
    frame_state_t          state_nxt;
    logic                  last_locked;
    logic                  lock_lost;
    logic [PLL_CNT_W-1:0]  pll_cnt;
    logic [HOLD_CNT_W-1:0] hold_cnt;
    logic                  pll_bad;
    logic                  rst_cause;

    //////////////////////////////////////////////////
    // PLL supervisor
    //////////////////////////////////////////////////

    assign lock_lost = last_locked & ~pll_locked;

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            last_locked <= 1'b0;
            pll_cnt     <= '0;
            pll_rst     <= 1'b0;
        end else begin
            last_locked <= pll_locked;
            if (lock_lost) begin
                // Reload on every lost lock
                pll_rst <= 1'b1;
                pll_cnt <= PLL_CNT_W'(PLL_RST_CYCLES - 1);
            end else if (pll_cnt != '0) begin
                pll_cnt <= pll_cnt - 1'b1;
            end else begin
                pll_rst <= 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////
    // Reset sequencing
    //////////////////////////////////////////////////

    assign pll_bad   = pll_rst | ~pll_locked;
    assign rst_cause = downloading | status[STATUS_RST_BIT] | pll_bad;

    // Reloaded by any cause and counted down in the cause-free cycles
    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET) begin
            hold_cnt <= HOLD_CNT_W'(RST_HOLD_CYCLES - 1);
        end else if (rst_cause) begin
            hold_cnt <= HOLD_CNT_W'(RST_HOLD_CYCLES - 1);
        end else if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 1'b1;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            ST_BOOT: begin
                if (pll_bad)
                    state_nxt = ST_RELOCK;
                else if (downloading)
                    state_nxt = ST_LOAD;
                else if (!rst_cause && hold_cnt == '0)
                    state_nxt = ST_RUN;
            end
            ST_LOAD: begin
                if (!downloading)
                    state_nxt = ST_BOOT;
            end
            ST_RUN: begin
                if (pll_bad)
                    state_nxt = ST_RELOCK;
                else if (downloading)
                    state_nxt = ST_LOAD;
                else if (status[STATUS_RST_BIT])
                    state_nxt = ST_BOOT;
            end
            ST_RELOCK: begin
                // Back to the hold phase once the PLL settles
                if (!pll_bad)
                    state_nxt = ST_BOOT;
            end
            default: state_nxt = ST_BOOT;
        endcase
    end

    always_ff @(posedge clk_sys or posedge RESET) begin
        if (RESET)
            state <= ST_BOOT;
        else
            state <= state_nxt;
    end

    // Game only runs in ST_RUN
    assign game_rst = (state != ST_RUN);
    assign mem_sel  = downloading ? MEM_PROG : MEM_READ;

    a_pll_holds_game: assert property (@(posedge clk_sys) disable iff (RESET)
        pll_rst |-> game_rst);

    // Loader owns the buffer only while the game is held
    a_prog_holds_game: assert property (@(posedge clk_sys) disable iff (RESET)
        (mem_sel == MEM_PROG) |=> game_rst);

endmodule

// File: hdl/frame_if.sv
//////////////////////////////////////////////////
// ROM program write bus and game read bus
//////////////////////////////////////////////////

// Byte-lane write bus, no acknowledge
interface rom_wr_if;
    import mem_pkg::*;

    logic [ROM_AW-1:0] prog_addr;
    logic [ROM_DW-1:0] prog_data;
    logic [1:0]        prog_mask;
    logic              prog_we;

    modport loader (
        output prog_addr,
        output prog_data,
        output prog_mask,
        output prog_we
    );

    modport mem (
        input prog_addr,
        input prog_data,
        input prog_mask,
        input prog_we
    );
endinterface

// Game side request / ack / ready handshake
interface rom_rd_if;
    import mem_pkg::*;

    logic              req;
    logic [ROM_AW-1:0] addr;
    logic              ack;
    logic              rdy;
    logic [ROM_DW-1:0] data;

    modport mem (
        input  req,
        input  addr,
        output ack,
        output rdy,
        output data
    );
endinterface

// File: hdl/mem_pkg.sv
//////////////////////////////////////////////////
// ROM buffer geometry and memory path select
//////////////////////////////////////////////////

package mem_pkg;

    // 16-bit words, word addressed
    localparam int ROM_AW    = 10;
    localparam int ROM_DW    = 16;
    localparam int ROM_WORDS = 1 << ROM_AW;

    // Byte capacity seen by the host loader
    localparam int ROM_BYTES = ROM_WORDS * (ROM_DW / 8);

    // Who owns the ROM buffer
    typedef enum logic {
        MEM_PROG,
        MEM_READ
    } mem_sel_t;

endpackage

// File: hdl/frame_pkg.sv
//////////////////////////////////////////////////
// Frame control types, status bits, register map
// and reset timing constants
//////////////////////////////////////////////////

package frame_pkg;

    // Control FSM states
    typedef enum logic [1:0] {
        ST_BOOT,
        ST_LOAD,
        ST_RUN,
        ST_RELOCK
    } frame_state_t;

    // Status word bit positions
    localparam int STATUS_RST_BIT   = 0;
    localparam int STATUS_PAUSE_BIT = 1;
    localparam int STATUS_FLIP_BIT  = 2;
    localparam int STATUS_TEST_BIT  = 3;

    // Host register byte offsets
    localparam logic [3:0] REG_STATUS   = 4'h0;
    localparam logic [3:0] REG_DIPSW    = 4'h4;
    localparam logic [3:0] REG_CORE_ID  = 4'h8;
    localparam logic [3:0] REG_LOAD_CNT = 4'hC;

    localparam logic [31:0] CORE_ID = 32'h4A46_0100;

    // AXI response codes
    localparam logic [1:0] AXI_OKAY   = 2'b00;
    localparam logic [1:0] AXI_SLVERR = 2'b10;

    // Reset timing, in clk_sys cycles
    localparam int RST_HOLD_CYCLES = 16;
    localparam int PLL_RST_CYCLES  = 256;
    localparam int HOLD_CNT_W      = $clog2(RST_HOLD_CYCLES + 1);
    localparam int PLL_CNT_W       = $clog2(PLL_RST_CYCLES);

endpackage
